/* logic/attn_bus_pkg.sv */
package attn_bus_pkg;

	import attn_cfg_pkg::*;

	// Broadcast from the feeder to all lanes
	typedef struct packed {
		logic clr;
		logic acc;
		logic signed [DATA_W-1:0] weight;
		logic [COL_W-1:0] col;
		// Entry j is the token operand for lane j
		logic [MAX_ROWS-1:0][DATA_W-1:0] op;
	} lane_feed_t;

	// Eight column sums of one token row
	typedef struct packed {
		logic [FEAT_N-1:0][ACC_W-1:0] acc;
	} lane_result_t;

	typedef struct packed {
		logic start;
		logic [ROW_W-1:0] t;
	} drain_cmd_t;

endpackage

/* logic/attn_cfg_pkg.sv */
package attn_cfg_pkg;

	// Features per token, also the side of the square weight matrix
	localparam int FEAT_N = 8;

	// One MAC lane per token row
	localparam int MAX_ROWS = 8;

	// Signed feature and weight width
	localparam int DATA_W = 8;

	// Eight 16-bit products summed need three extra bits
	localparam int ACC_W = 2 * DATA_W + $clog2(FEAT_N);

	// Width of the serial result port
	localparam int OUT_W = 64;

	// Serial load length and compute length
	localparam int LOAD_CYCLES = FEAT_N * FEAT_N;

	// Token count field, holds 1 to 8
	localparam int ROW_W = 4;

	// Column and feature index
	localparam int COL_W = $clog2(FEAT_N);

	// Lane select
	localparam int ROW_IDX_W = $clog2(MAX_ROWS);

	// Load and compute step counter
	localparam int STEP_W = $clog2(LOAD_CYCLES);

endpackage

/* logic/mac_lane.sv */
`timescale 1ns/1ps

module mac_lane (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  attn_bus_pkg::lane_feed_t               i_feed,
	input  logic signed [attn_cfg_pkg::DATA_W-1:0] i_lane_operand,
	output attn_bus_pkg::lane_result_t             o_result
);

	import attn_cfg_pkg::*;
	import attn_bus_pkg::*;

	logic signed [2*DATA_W-1:0] prod;
	lane_result_t acc_q;

	assign prod = i_lane_operand * $signed(i_feed.weight);

	// One column sum updated per step
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_q <= '0;
		end else if (i_feed.clr) begin
			acc_q <= '0;
		end else if (i_feed.acc) begin
			acc_q.acc[i_feed.col] <= $signed(acc_q.acc[i_feed.col]) + prod;
		end
	end

	assign o_result = acc_q;

endmodule

/* logic/proj_top.sv */
`timescale 1ns/1ps

module proj_top (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   i_in_valid,
	input  logic [attn_cfg_pkg::ROW_W-1:0]         i_t,
	input  logic signed [attn_cfg_pkg::DATA_W-1:0] i_in_data,
	input  logic signed [attn_cfg_pkg::DATA_W-1:0] i_weight,
	output logic                                   o_out_valid,
	output logic signed [attn_cfg_pkg::OUT_W-1:0]  o_out_data
);

	import attn_cfg_pkg::*;
	import attn_bus_pkg::*;

	lane_feed_t feed;
	drain_cmd_t drain_cmd;
	lane_result_t [MAX_ROWS-1:0] results;
	logic busy;
	logic done;

	token_feeder u_feeder (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_in_valid  (i_in_valid),
		.i_t         (i_t),
		.i_in_data   (i_in_data),
		.i_weight    (i_weight),
		.i_done      (done),
		.o_feed      (feed),
		.o_drain_cmd (drain_cmd),
		.o_busy      (busy)
	);

	// Lane g owns token row g
	for (genvar g = 0; g < MAX_ROWS; g++) begin : g_lane
		mac_lane u_lane (
			.clk            (clk),
			.rst_n          (rst_n),
			.i_feed         (feed),
			.i_lane_operand (feed.op[g]),
			.o_result       (results[g])
		);
	end

	result_drain u_drain (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_drain_cmd (drain_cmd),
		.i_results   (results),
		.i_busy      (busy),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data),
		.o_done      (done)
	);

endmodule

/* logic/result_drain.sv */
`timescale 1ns/1ps

module result_drain (
	input  logic                                                    clk,
	input  logic                                                    rst_n,
	input  attn_bus_pkg::drain_cmd_t                                i_drain_cmd,
	input  attn_bus_pkg::lane_result_t [attn_cfg_pkg::MAX_ROWS-1:0] i_results,
	input  logic                                                    i_busy,
	output logic                                                    o_out_valid,
	output logic signed [attn_cfg_pkg::OUT_W-1:0]                   o_out_data,
	output logic                                                    o_done
);

	import attn_cfg_pkg::*;
	import attn_bus_pkg::*;

	logic [ROW_W-1:0] row;
	logic [ROW_W-1:0] t_reg;
	logic [COL_W-1:0] col;
	logic start_ok;
	logic emit;
	lane_result_t cur_row;
	logic signed [ACC_W-1:0] cur_acc;

	// Pointer rests at (0, 0) between blocks
	assign cur_row = i_results[row[ROW_IDX_W-1:0]];
	assign cur_acc = cur_row.acc[col];

	assign start_ok = i_drain_cmd.start && i_busy && !o_out_valid;
	// Row reaching T means every row has been sent
	assign emit = start_ok || (o_out_valid && row != t_reg);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_out_valid <= 1'b0;
			o_out_data <= '0;
			o_done <= 1'b0;
			row <= '0;
			col <= '0;
			t_reg <= '0;
		end else begin
			o_done <= 1'b0;
			if (start_ok) begin
				t_reg <= i_drain_cmd.t;
			end
			if (emit) begin
				o_out_valid <= 1'b1;
				o_out_data <= OUT_W'(cur_acc);
				col <= col + 1'b1;
				if (col == COL_W'(FEAT_N - 1)) begin
					row <= row + 1'b1;
				end
			end else begin
				o_out_valid <= 1'b0;
				o_out_data <= '0;
				row <= '0;
				col <= '0;
				if (o_out_valid) begin
					o_done <= 1'b1;
				end
			end
		end
	end

endmodule

/* logic/token_feeder.sv */
`timescale 1ns/1ps

module token_feeder (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  i_in_valid,
	input  logic [attn_cfg_pkg::ROW_W-1:0]        i_t,
	input  logic signed [attn_cfg_pkg::DATA_W-1:0] i_in_data,
	input  logic signed [attn_cfg_pkg::DATA_W-1:0] i_weight,
	input  logic                                  i_done,
	output attn_bus_pkg::lane_feed_t              o_feed,
	output attn_bus_pkg::drain_cmd_t              o_drain_cmd,
	output logic                                  o_busy
);

	import attn_cfg_pkg::*;
	import attn_bus_pkg::*;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_LOAD,
		PH_COMPUTE
	} phase_t;

	phase_t phase;
	logic [STEP_W-1:0] step;
	logic [ROW_W-1:0] t_reg;
	logic busy;
	logic accept;
	logic [COL_W-1:0] feat;
	lane_feed_t feed_nxt;

	// Row-major X and W as they arrive
	logic signed [DATA_W-1:0] x_mem [LOAD_CYCLES];
	logic signed [DATA_W-1:0] w_mem [LOAD_CYCLES];

	// The drain's done pulse frees us on the same cycle
	assign accept = (phase == PH_IDLE) && i_in_valid && (!busy || i_done);

	// Step s reads input feature s/8
	assign feat = step[STEP_W-1:COL_W];

	// Step sits at zero in idle, so it addresses the store on the accept cycle too
	always_ff @(posedge clk) begin
		if (accept || phase == PH_LOAD) begin
			x_mem[step] <= i_in_data;
			w_mem[step] <= i_weight;
		end
	end

	always_comb begin
		feed_nxt = '0;
		feed_nxt.clr = accept;
		if (phase == PH_COMPUTE) begin
			feed_nxt.acc = 1'b1;
			feed_nxt.weight = w_mem[step];
			feed_nxt.col = step[COL_W-1:0];
			// Rows at or above T see a zero operand
			for (int j = 0; j < MAX_ROWS; j++) begin
				if (j < t_reg) begin
					feed_nxt.op[j] = x_mem[j * FEAT_N + int'(feat)];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_IDLE;
			step <= '0;
			t_reg <= '0;
			busy <= 1'b0;
			o_feed <= '0;
			o_drain_cmd <= '0;
		end else begin
			o_feed <= feed_nxt;
			// Last accumulate is still on the bus after phase went idle
			o_drain_cmd.start <= o_feed.acc && (phase == PH_IDLE);
			o_drain_cmd.t <= t_reg;
			if (i_done) begin
				busy <= 1'b0;
			end
			if (accept || phase != PH_IDLE) begin
				step <= step + 1'b1;
			end
			case (phase)
				PH_IDLE: begin
					if (accept) begin
						t_reg <= i_t;
						busy <= 1'b1;
						phase <= PH_LOAD;
					end
				end
				PH_LOAD: begin
					if (step == STEP_W'(LOAD_CYCLES - 1)) begin
						phase <= PH_COMPUTE;
					end
				end
				PH_COMPUTE: begin
					if (step == STEP_W'(LOAD_CYCLES - 1)) begin
						phase <= PH_IDLE;
					end
				end
				default: begin
					phase <= PH_IDLE;
				end
			endcase
		end
	end

	assign o_busy = busy;

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module proj_tb -f sim.f -o proj_sim

./obj_dir/proj_sim

/* sim.f */
logic/attn_cfg_pkg.sv
logic/attn_bus_pkg.sv
logic/token_feeder.sv
logic/mac_lane.sv
logic/result_drain.sv
logic/proj_top.sv
verif/proj_tb_assert.sv
verif/proj_tb.sv

/* verif/proj_tb.sv */
`timescale 1ns/1ps

module proj_tb;

	import attn_cfg_pkg::*;

	localparam int CLK_HALF = 5;

	// Edge that samples the last input to the first valid output
	localparam int LATENCY = 66;

	// Load, compute, drain start and a full output run, with some slack
	localparam int BLOCK_LEN = 2 * LOAD_CYCLES + 2 + FEAT_N * MAX_ROWS + 16;

	// Ten full blocks plus the one cut short by reset
	localparam int NUM_BLOCKS = 11;
	localparam int TIMEOUT_CYCLES = NUM_BLOCKS * BLOCK_LEN + 200;

	logic clk;
	logic rst_n;
	logic i_in_valid;
	logic [ROW_W-1:0] i_t;
	logic signed [DATA_W-1:0] i_in_data;
	logic signed [DATA_W-1:0] i_weight;
	logic o_out_valid;
	logic signed [OUT_W-1:0] o_out_data;

	integer seed;
	int cycle_cnt = 0;

	// Current block, both row-major
	logic signed [DATA_W-1:0] x_blk [LOAD_CYCLES];
	logic signed [DATA_W-1:0] w_blk [LOAD_CYCLES];

	proj_top proj_top_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_in_valid  (i_in_valid),
		.i_t         (i_t),
		.i_in_data   (i_in_data),
		.i_weight    (i_weight),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			abort_run("Timeout, the tests ran past the cycle limit");
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "run stopped: %s", why);
	endtask

	task automatic check_val(input string name, input logic signed [63:0] exp_v,
			input logic signed [63:0] act_v);
		if (exp_v !== act_v) begin
			$display("[FAIL] time=%0t %s expected=%0d actual=%0d", $time, name, exp_v, act_v);
			$display("=== FAIL ===");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// Y[row][col] = sum over k of X[row][k] * W[k][col]
	function automatic longint ref_value(input int row, input int col);
		longint sum;
		sum = 0;
		for (int k = 0; k < FEAT_N; k++) begin
			sum = sum + longint'(x_blk[row * FEAT_N + k]) * longint'(w_blk[k * FEAT_N + col]);
		end
		return sum;
	endfunction

	function automatic logic signed [DATA_W-1:0] junk_byte();
		logic signed [DATA_W-1:0] v;
		v = DATA_W'($random(seed));
		if (v == 0) begin
			v = 8'sd1;
		end
		return v;
	endfunction

	task automatic idle_inputs();
		i_in_valid = 1'b0;
		i_t = '0;
		i_in_data = '0;
		i_weight = '0;
	endtask

	task automatic fill_random();
		for (int n = 0; n < LOAD_CYCLES; n++) begin
			x_blk[n] = DATA_W'($random(seed));
			w_blk[n] = DATA_W'($random(seed));
		end
	endtask

	task automatic fill_const(input logic signed [DATA_W-1:0] xv,
			input logic signed [DATA_W-1:0] wv);
		for (int n = 0; n < LOAD_CYCLES; n++) begin
			x_blk[n] = xv;
			w_blk[n] = wv;
		end
	endtask

	// 64 cycles of input, junk past row T and on i_t after the first cycle
	task automatic load_block(input int t);
		for (int n = 0; n < LOAD_CYCLES; n++) begin
			@(posedge clk);
			#1;
			i_in_valid = 1'b1;
			i_t = (n == 0) ? ROW_W'(t) : ROW_W'($random(seed));
			if (n < FEAT_N * t) begin
				i_in_data = x_blk[n];
			end else begin
				i_in_data = junk_byte();
			end
			i_weight = w_blk[n];
		end
	endtask

	task automatic run_block(input int t, input bit hold_valid);
		int lat;
		int cnt;
		load_block(t);
		lat = 0;
		@(posedge clk);
		#1;
		while (!o_out_valid) begin
			// Optionally keep the input side busy during compute
			if (hold_valid && lat < LOAD_CYCLES) begin
				i_in_valid = 1'b1;
				i_in_data = junk_byte();
				i_weight = junk_byte();
			end else begin
				idle_inputs();
			end
			if (lat > 2 * LATENCY) begin
				abort_run("o_out_valid never rose after the block was loaded");
			end
			@(posedge clk);
			#1;
			lat++;
		end
		idle_inputs();
		check_val("o_out_valid latency", LATENCY, lat);
		cnt = 0;
		while (o_out_valid) begin
			if (cnt >= FEAT_N * t) begin
				abort_run("Output stream is longer than 8*T values");
			end
			check_val($sformatf("o_out_data[%0d][%0d]", cnt / FEAT_N, cnt % FEAT_N),
				ref_value(cnt / FEAT_N, cnt % FEAT_N), o_out_data);
			cnt++;
			@(posedge clk);
			#1;
		end
		if (cnt != FEAT_N * t) begin
			abort_run("Output stream ended before 8*T values");
		end
	endtask

	task automatic test_single_row();
		fill_random();
		run_block(1, 1'b0);
	endtask

	task automatic test_random_sizes();
		fill_random();
		run_block(4, 1'b0);
		fill_random();
		run_block(8, 1'b0);
	endtask

	// Largest positive and negative column sums
	task automatic test_extremes();
		fill_const(-8'sd128, -8'sd128);
		run_block(8, 1'b0);
		fill_const(8'sd127, -8'sd128);
		run_block(8, 1'b0);
	endtask

	task automatic test_back_to_back();
		fill_random();
		run_block(8, 1'b0);
		fill_random();
		run_block(3, 1'b1);
		fill_random();
		run_block(8, 1'b0);
	endtask

	task automatic test_reset_in_compute();
		fill_random();
		load_block(MAX_ROWS);
		@(posedge clk);
		#1;
		idle_inputs();
		// Halfway into compute
		repeat (LOAD_CYCLES / 2) @(posedge clk);
		#1;
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (LATENCY + FEAT_N * MAX_ROWS) begin
			@(posedge clk);
			#1;
			if (o_out_valid) begin
				abort_run("o_out_valid rose after a reset during compute");
			end
		end
		fill_random();
		run_block(5, 1'b0);
	endtask

	task automatic test_junk_rows();
		fill_random();
		run_block(4, 1'b0);
	endtask

	initial begin
		seed = 45;
		rst_n = 1'b0;
		idle_inputs();
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_single_row();
		test_random_sizes();
		test_extremes();
		test_back_to_back();
		test_reset_in_compute();
		test_junk_rows();
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* verif/proj_tb_assert.sv */
`timescale 1ns/1ps

module proj_tb_assert (
	input logic                              clk,
	input logic                              rst_n,
	input logic                              i_out_valid,
	input logic [attn_cfg_pkg::OUT_W-1:0]    i_out_data,
	input logic                              i_feed_clr,
	input logic                              i_drain_start
);

	import attn_cfg_pkg::*;

	// Valid cycles seen so far in the current run
	logic [6:0] run_len;

	// Set by the clear strobe and dropped when the drain starts
	logic in_block;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_len <= '0;
		end else if (i_out_valid) begin
			if (run_len != 7'h7f) begin
				run_len <= run_len + 1'b1;
			end
		end else begin
			run_len <= '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_block <= 1'b0;
		end else if (i_feed_clr) begin
			in_block <= 1'b1;
		end else if (i_drain_start) begin
			in_block <= 1'b0;
		end
	end

	idle_data_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!i_out_valid |-> i_out_data == '0)
		else $error("o_out_data is nonzero while o_out_valid is low");

	no_valid_in_block: assert property (@(posedge clk) disable iff (!rst_n)
		(i_feed_clr || in_block) |-> !i_out_valid)
		else $error("o_out_valid is high during load or compute");

	// Output only ever starts right after a drain start
	rise_after_start: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(i_out_valid) |-> $past(i_drain_start))
		else $error("o_out_valid rose without a drain start");

	run_len_limit: assert property (@(posedge clk) disable iff (!rst_n)
		i_out_valid |-> run_len < 7'(LOAD_CYCLES))
		else $error("o_out_valid stayed high for more than 64 cycles");

endmodule

bind proj_top proj_tb_assert proj_tb_assert_inst (
	.clk           (clk),
	.rst_n         (rst_n),
	.i_out_valid   (o_out_valid),
	.i_out_data    (o_out_data),
	.i_feed_clr    (feed.clr),
	.i_drain_start (drain_cmd.start)
);
